// File: design/misc_regs.sv
//////////////////////////////////////////////////
// misc control and status slave
// led bits, clock generator control and status,
// 16 bit scratch register, compat number
//////////////////////////////////////////////////
`timescale 1ns/1ps

module misc_regs
  (
   input  logic                                     wb_clk,
   input  logic                                     wb_rst,
   input  radio_ctrl_pkg::wb_req_t                  req_i,
   output radio_ctrl_pkg::wb_rsp_t                  rsp_o,
   input  logic [radio_ctrl_pkg::CGEN_ST_W-1:0]     cgen_st_i,
   output logic [1:0]                               leds_o,
   output logic                                     cgen_sync_b_o,
   output logic                                     cgen_ref_sel_o
  );

   radio_ctrl_pkg::wb_data_t reg_leds;
   radio_ctrl_pkg::wb_data_t reg_cgen_ctrl;
   radio_ctrl_pkg::wb_data_t reg_test;
   logic                     ack_q;
   logic                     wr_en;
   logic [6:0]               offs;

   assign offs  = req_i.adr[6:0];
   assign wr_en = req_i.cyc & req_i.stb & req_i.we & ~ack_q;

   //////////////////////////////////////////////////
   // write side
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= {14'd0, radio_ctrl_pkg::CGEN_CTRL_RESET};
         reg_test      <= '0;
      end
      else if (wr_en)
      begin
         case (offs)
            radio_ctrl_pkg::REG_LEDS:      reg_leds      <= req_i.dat;
            radio_ctrl_pkg::REG_CGEN_CTRL: reg_cgen_ctrl <= req_i.dat;
            radio_ctrl_pkg::REG_TEST:      reg_test      <= req_i.dat;
            default:                       ;   // status and compat are read only
         endcase
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_q <= 1'b0;
      else
         ack_q <= req_i.cyc & req_i.stb & ~ack_q;   // one pulse per strobe
   end

   //////////////////////////////////////////////////
   // read side, address held by master through ack
   always_comb
   begin
      case (offs)
         radio_ctrl_pkg::REG_LEDS:      rsp_o.dat = reg_leds;
         radio_ctrl_pkg::REG_CGEN_CTRL: rsp_o.dat = reg_cgen_ctrl;
         radio_ctrl_pkg::REG_CGEN_ST:   rsp_o.dat = {13'd0, cgen_st_i};
         radio_ctrl_pkg::REG_TEST:      rsp_o.dat = reg_test;
         radio_ctrl_pkg::REG_COMPAT:    rsp_o.dat = radio_ctrl_pkg::COMPAT_NUM;
         default:                       rsp_o.dat = radio_ctrl_pkg::MISC_DEFAULT_READ;
      endcase
   end

   assign rsp_o.ack = ack_q;

   // pin outputs
   assign leds_o         = reg_leds[1:0];
   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];

   // read data comes straight from offs, so the request must sit still until ack
   a_req_held: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (req_i.cyc && req_i.stb && !rsp_o.ack) |=>
         (req_i.stb && $stable(req_i.adr) && $stable(req_i.we)))
      else $error("misc request changed before ack");

endmodule

// File: design/radio_ctrl_core.sv
//////////////////////////////////////////////////
// radio control core top level
// address decoder, misc regs, settings bridge,
// time keeper and readback mux
//////////////////////////////////////////////////
`timescale 1ns/1ps

module radio_ctrl_core
  (
   input  logic                                 wb_clk,
   input  logic                                 wb_rst,
   input  radio_ctrl_pkg::wb_req_t              wb_req_i,
   output radio_ctrl_pkg::wb_rsp_t              wb_rsp_o,
   input  logic [radio_ctrl_pkg::CGEN_ST_W-1:0] cgen_st_i,
   input  logic                                 pps_i,
   output logic [1:0]                           leds_o,
   output logic                                 cgen_sync_b_o,
   output logic                                 cgen_ref_sel_o
  );

   radio_ctrl_pkg::wb_req_t    misc_req, rb_req, set_req;
   radio_ctrl_pkg::wb_rsp_t    misc_rsp, rb_rsp, set_rsp;
   radio_ctrl_pkg::set_bus_t   set_bus;
   radio_ctrl_pkg::set_data_t  test32;
   radio_ctrl_pkg::vita_time_t vita_time, vita_time_pps;

   //////////////////////////////////////////////////
   // decode
   wb_addr_decode u_decode
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .m_req_i(wb_req_i), .m_rsp_o(wb_rsp_o),
      .misc_req_o(misc_req), .rb_req_o(rb_req), .set_req_o(set_req),
      .misc_rsp_i(misc_rsp), .rb_rsp_i(rb_rsp), .set_rsp_i(set_rsp));

   // slave 0
   misc_regs u_misc
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(misc_req), .rsp_o(misc_rsp),
      .cgen_st_i(cgen_st_i), .leds_o(leds_o),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   // slaves 8 and 9, settings bus master
   settings_bridge u_settings
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(set_req), .rsp_o(set_rsp),
      .set_o(set_bus), .test32_o(test32));

   vita_timer u_timer
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_i(set_bus), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   // slave 7
   readback_mux u_readback
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(rb_req), .rsp_o(rb_rsp),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .test32_i(test32));

endmodule

// File: design/radio_ctrl_pkg.sv
//////////////////////////////////////////////////
// shared definitions for the radio control core
// bus widths, slave decode map, misc register
// offsets, settings and readback numbering,
// wishbone and settings bus structs
//////////////////////////////////////////////////
package radio_ctrl_pkg;

   //////////////////////////////////////////////////
   // widths
   localparam int WB_AW     = 11;
   localparam int WB_DW     = 16;
   localparam int SET_AW    = 8;
   localparam int SET_DW    = 32;
   localparam int TIME_W    = 64;
   localparam int CGEN_ST_W = 3;   // status, lock detect, ref monitor

   typedef logic [WB_AW-1:0]  wb_addr_t;
   typedef logic [WB_DW-1:0]  wb_data_t;
   typedef logic [SET_AW-1:0] set_addr_t;
   typedef logic [SET_DW-1:0] set_data_t;
   typedef logic [TIME_W-1:0] vita_time_t;

   //////////////////////////////////////////////////
   // slave decode on the top address bits
   localparam int DECODE_W = 4;
   localparam logic [DECODE_W-1:0] SLAVE_MISC     = 4'h0;
   localparam logic [DECODE_W-1:0] SLAVE_RB       = 4'h7;
   localparam logic [DECODE_W-1:0] SLAVE_SET      = 4'h8;
   localparam logic [DECODE_W-1:0] SLAVE_SET_MASK = 4'he;   // settings window is 8 and 9

   typedef enum logic [1:0]
   {
      SEL_MISC,
      SEL_RB,
      SEL_SET,
      SEL_NONE
   } slave_sel_e;

   // misc slave byte offsets, low 7 address bits
   localparam logic [6:0] REG_LEDS      = 7'd0;
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;
   localparam logic [6:0] REG_TEST      = 7'd8;
   localparam logic [6:0] REG_COMPAT    = 7'd16;

   localparam wb_data_t COMPAT_NUM        = 16'd6;
   localparam logic [1:0] CGEN_CTRL_RESET = 2'b11;   // sync_b high, ref_sel high
   localparam wb_data_t MISC_DEFAULT_READ = 16'hbeef;

   // settings register numbers
   localparam set_addr_t SR_TIME64     = 8'd42;   // +0 time high, +1 time low
   localparam set_addr_t SR_REG_TEST32 = 8'd60;

   // readback word indices
   localparam logic [3:0] RB_TIME_HI = 4'd0;
   localparam logic [3:0] RB_TIME_LO = 4'd1;
   localparam logic [3:0] RB_PPS_HI  = 4'd2;
   localparam logic [3:0] RB_PPS_LO  = 4'd3;
   localparam logic [3:0] RB_TEST32  = 4'd4;

   //////////////////////////////////////////////////
   // bus structs
   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_addr_t adr;
      logic [1:0] sel;
      wb_data_t dat;
   } wb_req_t;

   typedef struct packed {
      logic     ack;
      wb_data_t dat;
   } wb_rsp_t;

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

endpackage

// File: design/readback_mux.sv
//////////////////////////////////////////////////
// 16 bit readback window onto 32 bit status words
// word picked by adr[5:2], half by adr[1]
//////////////////////////////////////////////////
`timescale 1ns/1ps

module readback_mux
  (
   input  logic                       wb_clk,
   input  logic                       wb_rst,
   input  radio_ctrl_pkg::wb_req_t    req_i,
   output radio_ctrl_pkg::wb_rsp_t    rsp_o,
   input  radio_ctrl_pkg::vita_time_t vita_time_i,
   input  radio_ctrl_pkg::vita_time_t vita_time_pps_i,
   input  radio_ctrl_pkg::set_data_t  test32_i
  );

   radio_ctrl_pkg::set_data_t words [16];
   radio_ctrl_pkg::set_data_t word_sel;
   radio_ctrl_pkg::wb_data_t  dat_q;
   logic                      ack_q;

   always_comb
   begin
      for (int i = 0; i < 16; i++)
         words[i] = '0;   // unused slots read zero
      words[radio_ctrl_pkg::RB_TIME_HI] = vita_time_i[63:32];
      words[radio_ctrl_pkg::RB_TIME_LO] = vita_time_i[31:0];
      words[radio_ctrl_pkg::RB_PPS_HI]  = vita_time_pps_i[63:32];
      words[radio_ctrl_pkg::RB_PPS_LO]  = vita_time_pps_i[31:0];
      words[radio_ctrl_pkg::RB_TEST32]  = test32_i;
   end

   assign word_sel = words[req_i.adr[5:2]];

   // sample in the strobe cycle, present with ack
   always_ff @(posedge wb_clk)
   begin
      if (req_i.cyc & req_i.stb)
         dat_q <= req_i.adr[1] ? word_sel[31:16] : word_sel[15:0];
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_q <= 1'b0;
      else
         ack_q <= req_i.cyc & req_i.stb & ~ack_q;
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.dat = dat_q;

   // the half sampled in the strobe cycle must still be the one asked for at ack
   a_req_held: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (req_i.cyc && req_i.stb && !rsp_o.ack) |=> (req_i.stb && $stable(req_i.adr)))
      else $error("readback request changed before ack");

endmodule

// File: design/settings_bridge.sv
//////////////////////////////////////////////////
// 16 bit wishbone to 32 bit settings bus bridge
// low half is held, high half write fires the
// settings strobe; also holds the 32 bit test reg
//////////////////////////////////////////////////
`timescale 1ns/1ps

module settings_bridge
  (
   input  logic                      wb_clk,
   input  logic                      wb_rst,
   input  radio_ctrl_pkg::wb_req_t   req_i,
   output radio_ctrl_pkg::wb_rsp_t   rsp_o,
   output radio_ctrl_pkg::set_bus_t  set_o,
   output radio_ctrl_pkg::set_data_t test32_o
  );

   logic                      ack_q;
   logic                      wr_go;
   radio_ctrl_pkg::wb_data_t  low_q;
   logic                      set_stb_q;
   radio_ctrl_pkg::set_addr_t set_addr_q;
   radio_ctrl_pkg::set_data_t set_data_q;
   radio_ctrl_pkg::set_data_t test32_q;

   assign wr_go = req_i.cyc & req_i.stb & req_i.we & ~ack_q;

   //////////////////////////////////////////////////
   // handshake and settings strobe
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         ack_q     <= 1'b0;
         set_stb_q <= 1'b0;
      end
      else
      begin
         ack_q     <= req_i.cyc & req_i.stb & ~ack_q;
         set_stb_q <= wr_go & req_i.adr[1];   // lines up with ack
      end
   end

   // little endian, low half first
   always_ff @(posedge wb_clk)
   begin
      if (wr_go & ~req_i.adr[1])
         low_q <= req_i.dat;
      if (wr_go & req_i.adr[1])
      begin
         set_addr_q <= req_i.adr[9:2];   // 32 bit word number
         set_data_q <= {req_i.dat, low_q};
      end
   end

   // test register keeps its value across wb_rst so the host
   // can tell a running image from a freshly loaded one
   always_ff @(posedge wb_clk)
   begin
      if (set_stb_q && (set_addr_q == radio_ctrl_pkg::SR_REG_TEST32))
         test32_q <= set_data_q;
   end

   assign set_o.stb  = set_stb_q;
   assign set_o.addr = set_addr_q;
   assign set_o.data = set_data_q;
   assign test32_o   = test32_q;

   assign rsp_o.ack = ack_q;
   assign rsp_o.dat = '0;   // write only window

   // low half has no reset, a high half write must follow a low half write
   a_set_data_known: assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_o.stb |-> !$isunknown({set_o.addr, set_o.data}))
      else $error("settings strobe with unknown address or data");

endmodule

// File: design/vita_timer.sv
//////////////////////////////////////////////////
// 64 bit time keeper
// free running tick counter, load via settings
// bus, pps synchronizer and time latch on pps edge
//////////////////////////////////////////////////
`timescale 1ns/1ps

module vita_timer
  (
   input  logic                       wb_clk,
   input  logic                       wb_rst,
   input  radio_ctrl_pkg::set_bus_t   set_i,
   input  logic                       pps_i,
   output radio_ctrl_pkg::vita_time_t vita_time_o,
   output radio_ctrl_pkg::vita_time_t vita_time_pps_o
  );

   radio_ctrl_pkg::set_data_t time_hi_q;   // pending high word
   logic                      load_hi;
   logic                      load_lo;
   logic                      pps_meta;
   logic                      pps_sync;
   logic                      pps_dly;
   logic                      pps_rise;

   assign load_hi = set_i.stb & (set_i.addr == radio_ctrl_pkg::SR_TIME64);
   assign load_lo = set_i.stb & (set_i.addr == radio_ctrl_pkg::SR_TIME64 + 8'd1);

   always_ff @(posedge wb_clk)
   begin
      if (load_hi)
         time_hi_q <= set_i.data;
   end

   //////////////////////////////////////////////////
   // tick counter, low word write commits the load
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         vita_time_o <= '0;
      else if (load_lo)
         vita_time_o <= {time_hi_q, set_i.data};
      else
         vita_time_o <= vita_time_o + 64'd1;
   end

   // pps is asynchronous to wb_clk
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_dly  <= 1'b0;
      end
      else
      begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_dly  <= pps_sync;
      end
   end

   assign pps_rise = pps_sync & ~pps_dly;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         vita_time_pps_o <= '0;
      else if (pps_rise)
         vita_time_pps_o <= vita_time_o;   // snapshot on the edge
   end

endmodule

// File: design/wb_addr_decode.sv
//////////////////////////////////////////////////
// wishbone address decoder, single master
// routes strobes to misc, readback and settings
// slaves, muxes their responses back, and acks
// unmapped accesses with zero data
//////////////////////////////////////////////////
`timescale 1ns/1ps

module wb_addr_decode
  (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   input  radio_ctrl_pkg::wb_req_t m_req_i,
   output radio_ctrl_pkg::wb_rsp_t m_rsp_o,
   output radio_ctrl_pkg::wb_req_t misc_req_o,
   output radio_ctrl_pkg::wb_req_t rb_req_o,
   output radio_ctrl_pkg::wb_req_t set_req_o,
   input  radio_ctrl_pkg::wb_rsp_t misc_rsp_i,
   input  radio_ctrl_pkg::wb_rsp_t rb_rsp_i,
   input  radio_ctrl_pkg::wb_rsp_t set_rsp_i
  );

   logic [radio_ctrl_pkg::DECODE_W-1:0] dec;
   radio_ctrl_pkg::slave_sel_e          sel;
   logic                                none_ack;

   assign dec = m_req_i.adr[radio_ctrl_pkg::WB_AW-1 -: radio_ctrl_pkg::DECODE_W];

   always_comb
   begin
      if (dec == radio_ctrl_pkg::SLAVE_MISC)
         sel = radio_ctrl_pkg::SEL_MISC;
      else if (dec == radio_ctrl_pkg::SLAVE_RB)
         sel = radio_ctrl_pkg::SEL_RB;
      else if ((dec & radio_ctrl_pkg::SLAVE_SET_MASK) == radio_ctrl_pkg::SLAVE_SET)
         sel = radio_ctrl_pkg::SEL_SET;
      else
         sel = radio_ctrl_pkg::SEL_NONE;
   end

   // every slave sees the request, only the chosen one sees stb
   always_comb
   begin
      misc_req_o     = m_req_i;
      rb_req_o       = m_req_i;
      set_req_o      = m_req_i;
      misc_req_o.stb = m_req_i.stb & (sel == radio_ctrl_pkg::SEL_MISC);
      rb_req_o.stb   = m_req_i.stb & (sel == radio_ctrl_pkg::SEL_RB);
      set_req_o.stb  = m_req_i.stb & (sel == radio_ctrl_pkg::SEL_SET);
   end

   // nobody home, answer anyway so the master never hangs
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         none_ack <= 1'b0;
      else
         none_ack <= m_req_i.cyc & m_req_i.stb & (sel == radio_ctrl_pkg::SEL_NONE) & ~none_ack;
   end

   always_comb
   begin
      case (sel)
         radio_ctrl_pkg::SEL_MISC: m_rsp_o = misc_rsp_i;
         radio_ctrl_pkg::SEL_RB:   m_rsp_o = rb_rsp_i;
         radio_ctrl_pkg::SEL_SET:  m_rsp_o = set_rsp_i;
         default:
         begin
            m_rsp_o.ack = none_ack;
            m_rsp_o.dat = '0;
         end
      endcase
   end

   a_one_ack: assert property (@(posedge wb_clk) disable iff (wb_rst)
      $onehot0({misc_rsp_i.ack, rb_rsp_i.ack, set_rsp_i.ack, none_ack}))
      else $error("more than one slave acked at once");

endmodule

// File: list.f
design/radio_ctrl_pkg.sv
design/wb_addr_decode.sv
design/misc_regs.sv
design/settings_bridge.sv
design/vita_timer.sv
design/readback_mux.sv
design/radio_ctrl_core.sv
+incdir+testbench
testbench/tb_radio_ctrl.sv

// File: testbench/tb_bus_ops.svh
//////////////////////////////////////////////////
// wishbone bus tasks for the radio control bench
// single write and read with an ack timeout,
// galois lfsr for random data
//////////////////////////////////////////////////
`ifndef TB_BUS_OPS_SVH
`define TB_BUS_OPS_SVH

// wait for the slave ack, then drop the strobe in the next cycle
task automatic wait_ack(input radio_ctrl_pkg::wb_addr_t adr,
                        output radio_ctrl_pkg::wb_data_t dat);
   logic got;
   got = 1'b0;
   for (int n = 0; n < ACK_TIMEOUT && !got; n++)
   begin
      @(negedge wb_clk);   // ack and read data settled here
      got = wb_rsp.ack;
   end
   if (!got)
   begin
      $display("timeout: access to address %h got no ack within %0d cycles",
               adr, ACK_TIMEOUT);
      timed_out = 1'b1;
      @(posedge wb_clk);   // top level stops the sequence here
   end
   dat = wb_rsp.dat;
   @(posedge wb_clk);
   wb_req <= '0;
endtask

task automatic wb_write(input radio_ctrl_pkg::wb_addr_t adr,
                        input radio_ctrl_pkg::wb_data_t dat);
   radio_ctrl_pkg::wb_data_t unused;
   @(posedge wb_clk);
   wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, sel: 2'b11, dat: dat};
   wait_ack(adr, unused);
endtask

// lo and hi bound the value the read data check accepts
task automatic wb_read(input radio_ctrl_pkg::wb_addr_t adr,
                       input radio_ctrl_pkg::wb_data_t lo,
                       input radio_ctrl_pkg::wb_data_t hi,
                       output radio_ctrl_pkg::wb_data_t dat);
   exp_lo = lo;
   exp_hi = hi;
   rd_chk = 1'b1;
   chk_cnt++;
   @(posedge wb_clk);
   wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, sel: 2'b11, dat: 16'd0};
   wait_ack(adr, dat);
   rd_chk = 1'b0;
endtask

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] r;
   logic        b;
   r = '0;
   for (int i = 0; i < n; i++)
   begin
      b      = lfsr_q[0];
      lfsr_q = b ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
      r      = {r[30:0], b};
   end
   return r;
endfunction

`endif

// File: testbench/tb_radio_ctrl.sv
//////////////////////////////////////////////////
// testbench for the radio control core
// clock, reset, DUT, read data and pin checks,
// test sequence and summary
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_radio_ctrl;

   localparam int          ACK_TIMEOUT = 20;
   localparam logic [31:0] LFSR_SEED   = 32'hf0944b95;
   localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
   localparam radio_ctrl_pkg::wb_addr_t UNMAPPED_ADDR = {4'd3, 7'd0};

   logic                     wb_clk;
   logic                     wb_rst;
   radio_ctrl_pkg::wb_req_t  wb_req;
   radio_ctrl_pkg::wb_rsp_t  wb_rsp;
   logic [2:0]               cgen_st;
   logic                     pps;
   logic [1:0]               leds;
   logic                     cgen_sync_b;
   logic                     cgen_ref_sel;
   logic [31:0]              lfsr_q = LFSR_SEED;
   radio_ctrl_pkg::wb_data_t exp_lo;
   radio_ctrl_pkg::wb_data_t exp_hi;
   logic                     rd_chk;      // read data check armed
   logic                     timed_out;
   int                       err_cnt;
   int                       chk_cnt;

   `include "tb_bus_ops.svh"

   radio_ctrl_core u_dut
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
      .cgen_st_i(cgen_st), .pps_i(pps), .leds_o(leds),
      .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel));

   initial wb_clk = 1'b0;
   always #50 wb_clk = ~wb_clk;   // 100 ns period

   // read data must fall in the window set up by wb_read
   a_read_data: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (rd_chk && wb_rsp.ack) |-> (wb_rsp.dat >= exp_lo && wb_rsp.dat <= exp_hi))
   else
   begin
      err_cnt++;
      $display("** Error at %0t: read of %h gave %h, expected %h to %h", $time,
               $sampled(wb_req.adr), $sampled(wb_rsp.dat), $sampled(exp_lo),
               $sampled(exp_hi));
   end

   //////////////////////////////////////////////////
   // address helpers
   function automatic radio_ctrl_pkg::wb_addr_t misc_addr(input logic [6:0] offs);
      return {radio_ctrl_pkg::SLAVE_MISC, offs};
   endfunction

   function automatic radio_ctrl_pkg::wb_addr_t rb_addr(input logic [3:0] idx,
                                                        input logic hi);
      return {radio_ctrl_pkg::SLAVE_RB, 1'b0, idx, hi, 1'b0};
   endfunction

   function automatic radio_ctrl_pkg::wb_addr_t set_addr(input radio_ctrl_pkg::set_addr_t sr,
                                                         input logic hi);
      return {1'b1, sr, hi, 1'b0};   // lands in decode 8 or 9
   endfunction

   task automatic write_setting(input radio_ctrl_pkg::set_addr_t sr,
                                input radio_ctrl_pkg::set_data_t value);
      wb_write(set_addr(sr, 1'b0), value[15:0]);
      wb_write(set_addr(sr, 1'b1), value[31:16]);
   endtask

   task automatic check_rb_word(input logic [3:0] idx, input logic [31:0] value);
      radio_ctrl_pkg::wb_data_t d;
      wb_read(rb_addr(idx, 1'b0), value[15:0], value[15:0], d);
      wb_read(rb_addr(idx, 1'b1), value[31:16], value[31:16], d);
   endtask

   task automatic check_pins(input logic [1:0] exp_leds, input logic exp_sync_b,
                             input logic exp_ref_sel);
      @(negedge wb_clk);
      chk_cnt++;
      a_pins: assert (leds == exp_leds && cgen_sync_b == exp_sync_b &&
                      cgen_ref_sel == exp_ref_sel)
      else
      begin
         err_cnt++;
         $display("** Error at %0t: pins leds %b sync_b %b ref_sel %b, expected %b %b %b",
                  $time, leds, cgen_sync_b, cgen_ref_sel, exp_leds, exp_sync_b, exp_ref_sel);
      end
   endtask

   task automatic report_test(input int num, input string name, input int errs_before);
      if (err_cnt == errs_before)
         $display("test %0d %s: pass", num, name);
      else
         $display("test %0d %s: FAIL, %0d errors", num, name, err_cnt - errs_before);
   endtask

   //////////////////////////////////////////////////
   // test sequence
   task automatic run_tests();
      radio_ctrl_pkg::wb_data_t  d, leds_v, ctrl_v, test_v;
      radio_ctrl_pkg::wb_data_t  t_lo, t_before, t_after;
      radio_ctrl_pkg::set_data_t r, v0, v1, t_hi;
      int                        e;

      e = err_cnt;
      check_pins(2'b00, 1'b1, 1'b1);
      wb_read(misc_addr(radio_ctrl_pkg::REG_COMPAT), 16'd6, 16'd6, d);
      wb_read(UNMAPPED_ADDR, 16'd0, 16'd0, d);   // decoder answers itself
      report_test(1, "reset values", e);

      e = err_cnt;
      r = rand_bits(16);
      leds_v = r[15:0];
      r = rand_bits(16);
      ctrl_v = r[15:0];
      r = rand_bits(16);
      test_v = r[15:0];
      wb_write(misc_addr(radio_ctrl_pkg::REG_LEDS), leds_v);
      wb_write(misc_addr(radio_ctrl_pkg::REG_CGEN_CTRL), ctrl_v);
      wb_write(misc_addr(radio_ctrl_pkg::REG_TEST), test_v);
      wb_read(misc_addr(radio_ctrl_pkg::REG_LEDS), leds_v, leds_v, d);
      wb_read(misc_addr(radio_ctrl_pkg::REG_CGEN_CTRL), ctrl_v, ctrl_v, d);
      wb_read(misc_addr(radio_ctrl_pkg::REG_TEST), test_v, test_v, d);
      check_pins(leds_v[1:0], ctrl_v[1], ctrl_v[0]);
      r = rand_bits(3);
      @(posedge wb_clk);
      cgen_st <= r[2:0];
      wb_read(misc_addr(radio_ctrl_pkg::REG_CGEN_ST), {13'd0, r[2:0]}, {13'd0, r[2:0]}, d);
      wb_read(misc_addr(7'd12), 16'hbeef, 16'hbeef, d);
      report_test(2, "misc registers", e);

      e = err_cnt;
      v0 = rand_bits(32);
      v1 = rand_bits(32);
      write_setting(radio_ctrl_pkg::SR_REG_TEST32, v0);
      check_rb_word(radio_ctrl_pkg::RB_TEST32, v0);
      wb_write(set_addr(radio_ctrl_pkg::SR_REG_TEST32, 1'b0), v1[15:0]);
      check_rb_word(radio_ctrl_pkg::RB_TEST32, v0);   // low half alone fires nothing
      wb_write(set_addr(radio_ctrl_pkg::SR_REG_TEST32, 1'b1), v1[31:16]);
      check_rb_word(radio_ctrl_pkg::RB_TEST32, v1);
      report_test(3, "settings bridge", e);

      e = err_cnt;
      t_hi = rand_bits(32);
      write_setting(radio_ctrl_pkg::SR_TIME64, t_hi);
      write_setting(radio_ctrl_pkg::SR_TIME64 + 8'd1, 32'h1000_0000);
      check_rb_word(radio_ctrl_pkg::RB_TIME_HI, t_hi);
      wb_read(rb_addr(radio_ctrl_pkg::RB_TIME_LO, 1'b1), 16'h1000, 16'h1000, d);
      wb_read(rb_addr(radio_ctrl_pkg::RB_TIME_LO, 1'b0), 16'd0, 16'd200, t_lo);
      wb_read(rb_addr(radio_ctrl_pkg::RB_TIME_LO, 1'b0), t_lo + 16'd1, t_lo + 16'd200, d);
      report_test(4, "time load", e);

      e = err_cnt;
      wb_read(rb_addr(radio_ctrl_pkg::RB_TIME_LO, 1'b0), t_lo + 16'd1, t_lo + 16'd200, t_before);
      @(posedge wb_clk);
      pps <= 1'b1;
      repeat (4) @(posedge wb_clk);
      pps <= 1'b0;
      wb_read(rb_addr(radio_ctrl_pkg::RB_TIME_LO, 1'b0), t_before + 16'd1,
              t_before + 16'd200, t_after);
      wb_read(rb_addr(radio_ctrl_pkg::RB_PPS_LO, 1'b0), t_before, t_after, d);
      wb_read(rb_addr(radio_ctrl_pkg::RB_PPS_LO, 1'b1), 16'h1000, 16'h1000, d);
      check_rb_word(radio_ctrl_pkg::RB_TIME_HI, t_hi);
      check_rb_word(radio_ctrl_pkg::RB_PPS_HI, t_hi);
      report_test(5, "pps latch", e);

      e = err_cnt;
      @(posedge wb_clk);
      wb_rst <= 1'b1;
      repeat (3) @(posedge wb_clk);
      wb_rst <= 1'b0;
      check_rb_word(radio_ctrl_pkg::RB_TEST32, v1);
      wb_read(rb_addr(radio_ctrl_pkg::RB_TIME_LO, 1'b0), 16'd0, 16'd200, d);
      wb_read(rb_addr(radio_ctrl_pkg::RB_TIME_LO, 1'b1), 16'd0, 16'd0, d);
      check_rb_word(radio_ctrl_pkg::RB_TIME_HI, 32'd0);
      wb_read(misc_addr(radio_ctrl_pkg::REG_LEDS), 16'd0, 16'd0, d);
      check_pins(2'b00, 1'b1, 1'b1);
      report_test(6, "test register across reset", e);
   endtask

   initial
   begin
      wb_rst    = 1'b1;
      wb_req    = '0;
      cgen_st   = 3'd0;
      pps       = 1'b0;
      rd_chk    = 1'b0;
      timed_out = 1'b0;
      exp_lo    = '0;
      exp_hi    = '0;
      err_cnt   = 0;
      chk_cnt   = 0;
      repeat (3) @(posedge wb_clk);
      wb_rst <= 1'b0;
      fork
         run_tests();
         wait (timed_out);   // a stuck access ends the sequence early
      join_any
      disable fork;
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0 && !timed_out)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule
